// File: files.f
design/wl_pkg.sv
design/weight_buffer.sv
design/wb_read_master.sv
design/weight_load_ctrl.sv
design/weight_loader_top.sv
tb/weight_loader_asserts.sv
tb/weight_loader_tb.sv

// File: Makefile
# Verilator build and run for the weight loader testbench

VERILATOR ?= verilator
TOP       ?= weight_loader_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
JOBS      ?= 4

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/weight_loader_tb.sv
`timescale 1ns/1ps
`default_nettype none

module weight_loader_tb
  import wl_pkg::*;
();

  localparam int rows_mode0 = 64;
  localparam int rows_mode1 = 128;
  localparam int buf_depth  = 1024;
  localparam int num_layers = 12;
  localparam logic [31:0] rng_seed = 32'd61343;

  logic        clk;
  logic        reset;
  logic        start;
  layer_cfg_t  cfg;
  logic        tile_ready;
  logic        tile_release;
  logic        busy;
  adr_t        rd_adr;
  weight_t     rd_data;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  adr_t        wb_adr;
  weight_t     wb_dat_i;
  logic        wb_ack;

  // addresses the memory should see, in order
  adr_t        exp_adr[$];
  layer_cfg_t  layers[num_layers];
  logic [31:0] stim_rng;
  int          cycle_cnt;
  int          cycle_limit;

  weight_loader_top #(
    .rows_mode0 (rows_mode0),
    .rows_mode1 (rows_mode1),
    .buf_depth  (buf_depth)
  ) weight_loader_top_inst (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .cfg          (cfg),
    .tile_ready   (tile_ready),
    .tile_release (tile_release),
    .busy         (busy),
    .rd_adr       (rd_adr),
    .rd_data      (rd_data),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_i     (wb_dat_i),
    .wb_ack       (wb_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int draw(input int n);
    stim_rng = xorshift32(stim_rng);
    return int'(stim_rng % 32'(n));
  endfunction

  // memory contents depend on every address bit
  function automatic weight_t mem_word(input adr_t a);
    return {(a * 16'd40503) ^ 16'h1f2e, (~a) ^ 16'hc3a5};
  endfunction

  // tiles run while t*rows < of_count
  function automatic int tile_count(input layer_cfg_t c);
    int rows;
    int n;
    rows = c.mode ? rows_mode1 : rows_mode0;
    n = (int'(c.of_count) + rows - 1) / rows;
    if (n < 1)
      n = 1;
    return n;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_adr(input string name, input adr_t got, input adr_t exp);
    if (got !== exp)
      report_failure($sformatf("FAILED at time %0t: %s = %h, expected %h",
                               $time, name, got, exp));
  endtask

  task automatic check_word(input string name, input weight_t got, input weight_t exp);
    if (got !== exp)
      report_failure($sformatf("FAILED at time %0t: %s = %h, expected %h",
                               $time, name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      report_failure($sformatf("FAILED at time %0t: %s = %0d, expected %0d",
                               $time, name, got, exp));
  endtask

  ////////////////////////////////////////
  // wishbone memory with random stall
  ////////////////////////////////////////

  initial
  begin
    logic [31:0] mem_rng;
    int          stall_left;
    adr_t        want;
    mem_rng = xorshift32(rng_seed ^ 32'h0000_a5a5);
    stall_left = -1;
    wb_ack = 1'b0;
    wb_dat_i = '0;
    forever
    begin
      @(posedge clk);
      #1;
      if (wb_ack)
        wb_ack = 1'b0;
      else if (!reset && wb_cyc && wb_stb)
      begin
        if (stall_left < 0)
        begin
          mem_rng = xorshift32(mem_rng);
          stall_left = int'(mem_rng % 32'd4);
        end
        if (stall_left != 0)
          stall_left--;
        else if (exp_adr.size() == 0)
          report_failure("a Wishbone read came after the expected address list ran out");
        else
        begin
          want = exp_adr.pop_front();
          check_adr("wb_adr", wb_adr, want);
          wb_dat_i = mem_word(wb_adr);
          wb_ack = 1'b1;
          stall_left = -1;
        end
      end
    end
  end

  // cycle limit for the whole run
  initial
  begin
    cycle_cnt = 0;
    while (cycle_limit == 0 || cycle_cnt <= cycle_limit)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic build_layers();
    layer_cfg_t c;
    for (int i = 0; i < num_layers; i++)
    begin
      c.mode       = (draw(2) == 1);
      c.nif_kk     = 16'(1 + draw(40));
      c.of_count   = 16'(1 + draw(300));
      c.layer_base = 16'(draw(65536));
      layers[i]    = c;
    end
    // single-word tiles, then exact multiples in both modes
    layers[0].nif_kk   = 16'd1;
    layers[1].mode     = 1'b0;
    layers[1].of_count = 16'(2 * rows_mode0);
    layers[2].mode     = 1'b1;
    layers[2].of_count = 16'(2 * rows_mode1);
  endtask

  task automatic read_tile(input adr_t base, input int words);
    for (int i = 0; i < words; i++)
    begin
      rd_adr = 16'(i);
      @(posedge clk);
      #1;
      check_word("rd_data", rd_data, mem_word(16'(int'(base) + i)));
    end
  endtask

  task automatic run_layer(input layer_cfg_t c);
    int   tiles;
    int   seen;
    int   hold;
    adr_t base;
    tiles = tile_count(c);
    seen = 0;
    for (int t = 0; t < tiles; t++)
      for (int w = 0; w < int'(c.nif_kk); w++)
        exp_adr.push_back(16'(int'(c.layer_base) + t * int'(c.nif_kk) + w));
    cfg = c;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    // a second start mid-layer must change nothing
    repeat (2) @(posedge clk);
    #1;
    cfg.layer_base = ~c.layer_base;
    cfg.nif_kk = 16'd7;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    while (busy)
    begin
      if (tile_ready)
      begin
        base = 16'(int'(c.layer_base) + seen * int'(c.nif_kk));
        seen++;
        read_tile(base, int'(c.nif_kk));
        hold = draw(8);
        repeat (hold) @(posedge clk);
        #1;
        tile_release = 1'b1;
        @(posedge clk);
        #1;
        tile_release = 1'b0;
      end
      else
      begin
        @(posedge clk);
        #1;
      end
    end
    check_count("tile_ready rises", seen, tiles);
    check_count("addresses never read", exp_adr.size(), 0);
    repeat (3) @(posedge clk);
    #1;
  endtask

  initial
  begin
    reset = 1'b1;
    start = 1'b0;
    cfg = '0;
    tile_release = 1'b0;
    rd_adr = '0;
    cycle_limit = 0;
    stim_rng = rng_seed;
    build_layers();
    cycle_limit = 2000;
    foreach (layers[i])
      cycle_limit += tile_count(layers[i]) * int'(layers[i].nif_kk) * 8;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (layers[i])
      run_layer(layers[i]);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/weight_loader_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module weight_loader_asserts
  import wl_pkg::*;
#(
  parameter int buf_depth = 1024
)
(
  input wire          clk,
  input wire          reset,
  input wire          wb_cyc,
  input wire          wb_stb,
  input wire          wb_we,
  input wire adr_t    wb_adr,
  input wire          wb_ack,
  input wire buf_wr_t buf_wr
);

  // strobe only inside a bus cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
    else $error("wb_stb high while wb_cyc is low");

  // address held until the slave acks
  adr_stable: assert property (@(posedge clk) disable iff (reset)
    (wb_stb && !wb_ack) |=> $stable(wb_adr))
    else $error("wb_adr changed during a stalled strobe");

  // read-only master
  no_write: assert property (@(posedge clk) disable iff (reset) !wb_we)
    else $error("wb_we went high");

  buf_in_range: assert property (@(posedge clk) disable iff (reset)
    buf_wr.en |-> (int'(buf_wr.adr) < buf_depth))
    else $error("buffer write address beyond buffer depth");

endmodule

bind weight_loader_top weight_loader_asserts #(
  .buf_depth (buf_depth)
) weight_loader_asserts_inst (
  .clk    (clk),
  .reset  (reset),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_we  (wb_we),
  .wb_adr (wb_adr),
  .wb_ack (wb_ack),
  .buf_wr (buf_wr)
);

`default_nettype wire

// File: design/weight_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module weight_loader_top
  import wl_pkg::*;
#(
  parameter int rows_mode0 = 64,
  parameter int rows_mode1 = 128,
  parameter int buf_depth  = 1024
)
(
  input  wire             clk,
  input  wire             reset,
  // layer setup
  input  wire             start,
  input  wire layer_cfg_t cfg,
  // tile handshake with the compute array
  output logic            tile_ready,
  input  wire             tile_release,
  output logic            busy,
  input  wire adr_t       rd_adr,
  output weight_t         rd_data,
  // read-only wishbone classic master
  output logic            wb_cyc,
  output logic            wb_stb,
  output logic            wb_we,
  output adr_t            wb_adr,
  input  wire weight_t    wb_dat_i,
  input  wire             wb_ack
);

  rd_req_t req;
  logic    req_ready;
  logic    ld_valid;
  weight_t ld_data;
  buf_wr_t buf_wr;

  weight_load_ctrl #(
    .rows_mode0 (rows_mode0),
    .rows_mode1 (rows_mode1)
  ) weight_load_ctrl_inst (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .cfg          (cfg),
    .req_ready    (req_ready),
    .req          (req),
    .ld_valid     (ld_valid),
    .ld_data      (ld_data),
    .buf_wr       (buf_wr),
    .tile_release (tile_release),
    .tile_ready   (tile_ready),
    .busy         (busy)
  );

  wb_read_master wb_read_master_inst (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .req_ready (req_ready),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack),
    .ld_valid  (ld_valid),
    .ld_data   (ld_data)
  );

  weight_buffer #(
    .buf_depth (buf_depth)
  ) weight_buffer_inst (
    .clk     (clk),
    .wr      (buf_wr),
    .rd_adr  (rd_adr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// File: design/weight_load_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module weight_load_ctrl
  import wl_pkg::*;
#(
  parameter int rows_mode0 = 64,
  parameter int rows_mode1 = 128
)
(
  input  wire             clk,
  input  wire             reset,
  input  wire             start,
  input  wire layer_cfg_t cfg,
  input  wire             req_ready,
  output rd_req_t         req,
  input  wire             ld_valid,
  input  wire weight_t    ld_data,
  output buf_wr_t         buf_wr,
  input  wire             tile_release,
  output logic            tile_ready,
  output logic            busy
);

  layer_cfg_t  cfg_q;
  logic        req_active;
  adr_t        word_cnt;
  logic [15:0] tile_start;
  adr_t        tile_base;
  adr_t        wr_cnt;
  logic [15:0] rows;
  logic        accept;
  logic        take;
  logic        last_req;
  logic        last_wr;
  logic        last_tile;
  logic        release_ok;

  assign rows = cfg_q.mode ? 16'(rows_mode1) : 16'(rows_mode0);

  assign accept     = start && !busy;
  assign take       = req_active && req_ready;
  assign last_req   = take && (word_cnt == cfg_q.nif_kk - 16'd1);
  assign last_wr    = ld_valid && (wr_cnt == cfg_q.nif_kk - 16'd1);
  assign release_ok = tile_ready && tile_release;

  // 17 bits so a large start plus rows cannot wrap
  assign last_tile = ({1'b0, tile_start} + {1'b0, rows}) >= {1'b0, cfg_q.of_count};

  ////////////////////////////////////////
  // layer control
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (accept)
      cfg_q <= cfg;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      busy <= 1'b0;
    else if (accept)
      busy <= 1'b1;
    else if (release_ok && last_tile)
      busy <= 1'b0;
  end

  // tile start in output channels, tile base in memory words
  always_ff @(posedge clk)
  begin
    if (reset || accept)
    begin
      tile_start <= '0;
      tile_base  <= '0;
    end
    else if (release_ok && !last_tile)
    begin
      tile_start <= tile_start + rows;
      tile_base  <= tile_base + cfg_q.nif_kk;
    end
  end

  ////////////////////////////////////////
  // memory requests
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
      req_active <= 1'b0;
    else if (accept)
      req_active <= 1'b1;
    else if (release_ok && !last_tile)
      req_active <= 1'b1;
    else if (last_req)
      req_active <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (reset || accept)
      word_cnt <= '0;
    else if (take)
      word_cnt <= last_req ? '0 : word_cnt + 16'd1;
  end

  assign req = '{en: take, adr: cfg_q.layer_base + tile_base + word_cnt};

  ////////////////////////////////////////
  // buffer writes and tile hold
  ////////////////////////////////////////

  // words come back in request order
  always_ff @(posedge clk)
  begin
    if (reset || accept)
      wr_cnt <= '0;
    else if (ld_valid)
      wr_cnt <= last_wr ? '0 : wr_cnt + 16'd1;
  end

  assign buf_wr = '{en: ld_valid, adr: wr_cnt, data: ld_data};

  // held until the compute side lets go
  always_ff @(posedge clk)
  begin
    if (reset)
      tile_ready <= 1'b0;
    else if (last_wr)
      tile_ready <= 1'b1;
    else if (release_ok)
      tile_ready <= 1'b0;
  end

endmodule

`default_nettype wire

// File: design/wb_read_master.sv
`timescale 1ns/1ps
`default_nettype none

module wb_read_master
  import wl_pkg::*;
(
  input  wire          clk,
  input  wire          reset,
  input  wire rd_req_t req,
  output logic         req_ready,
  output logic         wb_cyc,
  output logic         wb_stb,
  output logic         wb_we,
  output adr_t         wb_adr,
  input  wire weight_t wb_dat_i,
  input  wire          wb_ack,
  output logic         ld_valid,
  output weight_t      ld_data
);

  typedef enum logic {
    st_idle,
    st_bus
  } state_t;

  state_t state;
  logic   take;
  logic   done;

  assign req_ready = (state == st_idle);
  assign take      = req.en && req_ready;
  assign done      = (state == st_bus) && wb_ack;

  // one classic read cycle per request
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= st_idle;
    else
    begin
      case (state)
        st_idle:
          if (take)
            state <= st_bus;
        st_bus:
          if (wb_ack)
            state <= st_idle;
        default:
          state <= st_idle;
      endcase
    end
  end

  assign wb_cyc = (state == st_bus);
  assign wb_stb = (state == st_bus);
  // read only
  assign wb_we  = 1'b0;

  always_ff @(posedge clk)
  begin
    if (take)
      wb_adr <= req.adr;
  end

  always_ff @(posedge clk)
  begin
    if (done)
      ld_data <= wb_dat_i;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      ld_valid <= 1'b0;
    else
      ld_valid <= done;
  end

endmodule

`default_nettype wire

// File: design/weight_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module weight_buffer
  import wl_pkg::*;
#(
  parameter int buf_depth = 1024
)
(
  input  wire          clk,
  input  wire buf_wr_t wr,
  input  wire adr_t    rd_adr,
  output weight_t      rd_data
);

  // index width into the array
  localparam int aw = (buf_depth > 1) ? $clog2(buf_depth) : 1;

  weight_t mem [buf_depth];

  logic [aw-1:0] wr_idx;
  logic [aw-1:0] rd_idx;

  assign wr_idx = wr.adr[aw-1:0];
  assign rd_idx = rd_adr[aw-1:0];

  ////////////////////////////////////////
  // write port from the loader
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (wr.en)
      mem[wr_idx] <= wr.data;
  end

  ////////////////////////////////////////
  // registered read for the compute side
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    rd_data <= mem[rd_idx];
  end

endmodule

`default_nettype wire

// File: design/wl_pkg.sv
`default_nettype none

package wl_pkg;

  // word address on both the memory and the buffer side
  typedef logic [15:0] adr_t;

  // one weight word
  typedef logic [31:0] weight_t;

  // per-layer setup latched on start
  typedef struct packed {
    logic        mode;
    logic [15:0] nif_kk;
    logic [15:0] of_count;
    adr_t        layer_base;
  } layer_cfg_t;

  // one write into the weight buffer
  typedef struct packed {
    logic    en;
    adr_t    adr;
    weight_t data;
  } buf_wr_t;

  // one single-word read request toward the bus master
  typedef struct packed {
    logic en;
    adr_t adr;
  } rd_req_t;

endpackage

`default_nettype wire
